//--- list.f
+incdir+source
source/issue_pkg.sv
source/decode_if.sv
source/writeback_if.sv
source/instr_buffer.sv
source/scoreboard.sv
source/exec_pipe.sv
source/issue_top.sv
verification/tb_issue_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and judge the run by its log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_issue_top -f list.f -o tb_issue_top \
    > build.log 2>&1 \
    && ./obj_dir/tb_issue_top > sim.log 2>&1 \
    || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "run failed"; exit 1; } || echo "run clean"

//--- verification/tb_issue_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "issue_cfg.svh"

module tb_issue_top import issue_pkg::*; ();

    localparam int          PERIOD      = 40;
    localparam int          RAND_COUNT  = 64;
    localparam int          TEST_INSTRS = 10 + RAND_COUNT;  // directed plus random
    localparam int          MAX_INSTR   = 128;
    localparam int          DRAIN_LIMIT = 2000;
    localparam logic [31:0] PC_BASE     = 32'h0000_1000;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    wid_t        in_wid;
    tmask_t      in_tmask;
    exu_op_e     in_op;
    reg_idx_t    in_rd;
    reg_idx_t    in_rs1;
    reg_idx_t    in_rs2;
    logic [31:0] in_pc;
    logic        wb_valid;
    logic        wb_ready;
    wid_t        wb_wid;
    reg_idx_t    wb_rd;
    tmask_t      wb_tmask;
    logic [31:0] wb_pc;

    // the reference model keeps one record per pushed instruction indexed by its pc
    int          instr_count;
    int          wb_count;
    int          writer_count;
    int          num_checks;
    int          num_errors;
    logic        exp_writes  [MAX_INSTR];
    wid_t        exp_wid     [MAX_INSTR];
    reg_idx_t    exp_rd      [MAX_INSTR];
    tmask_t      exp_tmask   [MAX_INSTR];
    int          deps        [MAX_INSTR][3];  // older writers that must complete first
    int          wb_order    [MAX_INSTR];
    int          last_writer [`NUM_WARPS][`NUM_REGS];
    int          pending_q   [$];             // writers still waiting for writeback

    logic        bp_enable;
    logic [31:0] stim_state;
    logic [31:0] bp_state;

    issue_top i_issue_top (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_wid   (in_wid),
        .in_tmask (in_tmask),
        .in_op    (in_op),
        .in_rd    (in_rd),
        .in_rs1   (in_rs1),
        .in_rs2   (in_rs2),
        .in_pc    (in_pc),
        .wb_valid (wb_valid),
        .wb_ready (wb_ready),
        .wb_wid   (wb_wid),
        .wb_rd    (wb_rd),
        .wb_tmask (wb_tmask),
        .wb_pc    (wb_pc)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        num_checks++;
        if (actual !== expected) begin
            num_errors++;
            $display("Fail at %0d ns: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic report_error(input string msg);
        num_errors++;
        $display("Error at %0d ns: %s", $time, msg);
    endtask

    task automatic push_instr(input wid_t wid, input exu_op_e op, input reg_idx_t rd,
                              input reg_idx_t rs1, input reg_idx_t rs2, input tmask_t tmask);
        int idx;
        idx = instr_count;
        instr_count++;
        exp_writes[idx] = (op == op_alu) || (op == op_mul);
        exp_wid[idx]    = wid;
        exp_rd[idx]     = rd;
        exp_tmask[idx]  = tmask;
        deps[idx][0]    = last_writer[wid][rs1];
        deps[idx][1]    = last_writer[wid][rs2];
        deps[idx][2]    = exp_writes[idx] ? last_writer[wid][rd] : -1;  // write after write
        if (exp_writes[idx]) begin
            last_writer[wid][rd] = idx;
            pending_q.push_back(idx);
            writer_count++;
        end
        in_valid <= 1'b1;
        in_wid   <= wid;
        in_op    <= op;
        in_rd    <= rd;
        in_rs1   <= rs1;
        in_rs2   <= rs2;
        in_tmask <= tmask;
        in_pc    <= PC_BASE + 32'(idx) * 32'd4;
        do begin
            @(posedge clk);
        end while (!in_ready);
    endtask

    task automatic observe_writeback();
        int idx;
        int pos;
        idx = int'((wb_pc - PC_BASE) >> 2);
        pos = -1;
        if (wb_pc < PC_BASE || wb_pc[1:0] != 2'b00 || idx >= instr_count) begin
            report_error($sformatf("writeback with unknown pc %0h", wb_pc));
        end else if (!exp_writes[idx]) begin
            report_error($sformatf("non-writing instruction at pc %0h wrote back", wb_pc));
        end else if (wb_order[idx] >= 0) begin
            report_error($sformatf("instruction at pc %0h wrote back twice", wb_pc));
        end else begin
            check_value("wb_wid", 32'(wb_wid), 32'(exp_wid[idx]));
            check_value("wb_rd", 32'(wb_rd), 32'(exp_rd[idx]));
            check_value("wb_tmask", 32'(wb_tmask), 32'(exp_tmask[idx]));
            for (int k = 0; k < 3; k++) begin
                if (deps[idx][k] >= 0 && wb_order[deps[idx][k]] < 0) begin
                    report_error($sformatf("pc %0h wrote back before the older writer at pc %0h",
                                           wb_pc, PC_BASE + 32'(deps[idx][k]) * 32'd4));
                end
            end
            wb_order[idx] = wb_count;
            wb_count++;
            foreach (pending_q[i]) begin
                if (pending_q[i] == idx) pos = i;
            end
            pending_q.delete(pos);
        end
    endtask

    // wait until every expected writeback arrived and the port is idle
    task automatic drain_and_check(input string test_name);
        int cycles;
        cycles = 0;
        in_valid <= 1'b0;
        do begin
            @(negedge clk);
            cycles++;
        end while ((pending_q.size() != 0 || wb_valid) && cycles < DRAIN_LIMIT);
        if (pending_q.size() != 0) begin
            report_error($sformatf("%s test left %0d writebacks missing", test_name,
                                   pending_q.size()));
        end
        check_value("wb_valid", 32'(wb_valid), 32'd0);
        @(posedge clk);
    endtask

    task automatic reset_state();
        check_value("in_ready", 32'(in_ready), 32'd1);
        check_value("wb_valid", 32'(wb_valid), 32'd0);
    endtask

    task automatic independent_flow();
        push_instr(2'd0, op_alu, 5'd3, 5'd1, 5'd2, 4'hf);
        push_instr(2'd1, op_mul, 5'd4, 5'd1, 5'd2, 4'h5);
        drain_and_check("independent");
    endtask

    task automatic read_after_write();
        push_instr(2'd2, op_mul, 5'd5, 5'd1, 5'd2, 4'hf);
        push_instr(2'd2, op_alu, 5'd6, 5'd5, 5'd0, 4'h3);  // reads the mul result
        push_instr(2'd3, op_alu, 5'd7, 5'd1, 5'd2, 4'hc);  // free to pass the mul
        drain_and_check("raw");
    endtask

    task automatic write_after_write();
        push_instr(2'd1, op_mul, 5'd8, 5'd1, 5'd2, 4'h9);
        push_instr(2'd1, op_alu, 5'd8, 5'd3, 5'd4, 4'ha);
        drain_and_check("waw");
    endtask

    task automatic non_writing_ops();
        push_instr(2'd0, op_nop, 5'd9, 5'd9, 5'd9, 4'hf);
        push_instr(2'd0, op_branch, 5'd9, 5'd9, 5'd9, 4'hf);
        // a reservation left by either one would hang this alu
        push_instr(2'd0, op_alu, 5'd9, 5'd9, 5'd9, 4'h6);
        drain_and_check("non-writing");
    endtask

    task automatic random_mix();
        logic [31:0] r;
        tmask_t      tm;
        bp_enable <= 1'b1;
        for (int n = 0; n < RAND_COUNT; n++) begin
            stim_state = xorshift(stim_state);
            r  = stim_state;
            tm = r[16:13];
            if (tm == '0) tm = '1;
            // only eight registers so that hazards are frequent
            push_instr(r[1:0], exu_op_e'(r[3:2]), {2'b00, r[6:4]}, {2'b00, r[9:7]},
                       {2'b00, r[12:10]}, tm);
            if (r[19:18] == 2'b00) begin
                in_valid <= 1'b0;
                @(posedge clk);
            end
        end
        bp_enable <= 1'b0;
        drain_and_check("random");
    endtask

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (bp_enable) begin
            bp_state = xorshift(bp_state);
            wb_ready <= (bp_state[31:29] > 3'd2);
        end else begin
            wb_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!reset && wb_valid && wb_ready) observe_writeback();
    end

    initial begin
        repeat (400 * TEST_INSTRS) @(posedge clk);
        $display("Error at %0d ns: watchdog expired before the tests finished", $time);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_wid       = '0;
        in_tmask     = '0;
        in_op        = op_nop;
        in_rd        = '0;
        in_rs1       = '0;
        in_rs2       = '0;
        in_pc        = '0;
        wb_ready     = 1'b1;
        bp_enable    = 1'b0;
        stim_state   = 32'hc6cf;
        bp_state     = 32'hc6cf;
        instr_count  = 0;
        wb_count     = 0;
        writer_count = 0;
        num_checks   = 0;
        num_errors   = 0;
        foreach (wb_order[i]) wb_order[i] = -1;
        foreach (last_writer[w, g]) last_writer[w][g] = -1;

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        reset_state();
        independent_flow();
        read_after_write();
        write_after_write();
        non_writing_ops();
        random_mix();
        check_value("writeback count", 32'(wb_count), 32'(writer_count));

        $display("checks: %0d, errors: %0d", num_checks, num_errors);
        if (num_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/issue_top.sv
`timescale 1ns/10ps
`default_nettype none

module issue_top import issue_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    // decoded instructions in
    input  logic        in_valid,
    output logic        in_ready,
    input  wid_t        in_wid,
    input  tmask_t      in_tmask,
    input  exu_op_e     in_op,
    input  reg_idx_t    in_rd,
    input  reg_idx_t    in_rs1,
    input  reg_idx_t    in_rs2,
    input  logic [31:0] in_pc,

    // completed instructions out
    output logic        wb_valid,
    input  logic        wb_ready,
    output wid_t        wb_wid,
    output reg_idx_t    wb_rd,
    output tmask_t      wb_tmask,
    output logic [31:0] wb_pc
);
    wid_t deq_wid_next;
    logic exe_delay;

    decode_if    deq_if ();
    writeback_if wb_if ();

    instr_buffer i_instr_buffer (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_wid       (in_wid),
        .in_tmask     (in_tmask),
        .in_op        (in_op),
        .in_rd        (in_rd),
        .in_rs1       (in_rs1),
        .in_rs2       (in_rs2),
        .in_pc        (in_pc),
        .deq          (deq_if.source),
        .deq_wid_next (deq_wid_next)
    );

    scoreboard i_scoreboard (
        .clk          (clk),
        .reset        (reset),
        .issue        (deq_if.sink),
        .wb           (wb_if.sink),
        .deq_wid_next (deq_wid_next),
        .exe_delay    (exe_delay)
    );

    exec_pipe i_exec_pipe (
        .clk       (clk),
        .reset     (reset),
        .issue     (deq_if.monitor),
        .wb        (wb_if.source),
        .exe_delay (exe_delay)
    );

    // back-pressure comes straight from the consumer of the writeback port
    assign wb_if.ready = wb_ready;

    assign wb_valid = wb_if.valid;
    assign wb_wid   = wb_if.wid;
    assign wb_rd    = wb_if.rd;
    assign wb_tmask = wb_if.tmask;
    assign wb_pc    = wb_if.pc;

endmodule

`default_nettype wire

//--- source/exec_pipe.sv
`timescale 1ns/10ps
`default_nettype none

`include "issue_cfg.svh"

module exec_pipe import issue_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    decode_if.monitor   issue,
    writeback_if.source wb,
    output logic        exe_delay
);
    localparam int MAX = `MAX_LATENCY;
    localparam int SW  = $clog2(MAX);

    // position 0 starts the pipeline and MAX-1 feeds writeback
    logic [MAX-1:0] occ;
    logic [MAX-1:0] s_wb;
    wid_t           s_wid   [MAX];
    reg_idx_t       s_rd    [MAX];
    tmask_t         s_tmask [MAX];
    logic [31:0]    s_pc    [MAX];

    logic           frozen, conflict, fire;
    logic [SW-1:0]  entry;

    // an instruction of latency L starts L-1 shifts away from the last slot
    function automatic logic [SW-1:0] entry_slot(exu_op_e op);
        if (op == op_mul) begin
            return SW'(MAX - `MUL_LATENCY);
        end
        return SW'(MAX - `ALU_LATENCY);  // alu and branch share this slot
    endfunction

    assign entry  = entry_slot(issue.op);
    assign frozen = wb.valid && !wb.ready;
    assign fire   = issue.valid && issue.ready && (issue.op != op_nop);

    // the entry slot must not receive an older instruction moving up from below it
    always_comb begin
        conflict = 1'b0;
        if (issue.valid && issue.op != op_nop && entry != '0) begin
            conflict = occ[entry - 1'b1];
        end
    end

    assign exe_delay = frozen || conflict;

    always_ff @(posedge clk) begin
        if (reset) begin
            occ <= '0;
        end else if (!frozen) begin
            occ <= {occ[MAX-2:0], 1'b0};
            if (fire) begin
                occ[entry] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!frozen) begin
            for (int i = MAX - 1; i > 0; i--) begin
                s_wb[i]    <= s_wb[i-1];
                s_wid[i]   <= s_wid[i-1];
                s_rd[i]    <= s_rd[i-1];
                s_tmask[i] <= s_tmask[i-1];
                s_pc[i]    <= s_pc[i-1];
            end
            if (fire) begin
                s_wb[entry]    <= issue.wb;
                s_wid[entry]   <= issue.wid;
                s_rd[entry]    <= issue.rd;
                s_tmask[entry] <= issue.tmask;
                s_pc[entry]    <= issue.pc;
            end
        end
    end

    // a branch reaching the last slot just drops out without a writeback
    assign wb.valid = occ[MAX-1] && s_wb[MAX-1];
    assign wb.wid   = s_wid[MAX-1];
    assign wb.rd    = s_rd[MAX-1];
    assign wb.tmask = s_tmask[MAX-1];
    assign wb.pc    = s_pc[MAX-1];

endmodule

`default_nettype wire

//--- source/scoreboard.sv
`timescale 1ns/10ps
`default_nettype none

`include "issue_cfg.svh"

module scoreboard import issue_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    decode_if.sink    issue,
    writeback_if.sink wb,
    input  wid_t      deq_wid_next,
    input  logic      exe_delay
);
    localparam int NW = `NUM_WARPS;

    // writeback always carries the full mask, so one bit per register is enough
    reg_mask_t [NW-1:0] pending, pending_n;
    reg_mask_t          deq_pending;  // row of the warp the buffer presents this cycle
    reg_mask_t          hazard_regs;
    logic               hazard;
    logic               reserve_reg, release_reg;

    assign reserve_reg = issue.valid && issue.ready && issue.wb;
    assign release_reg = wb.valid && wb.ready;

    always_comb begin
        pending_n = pending;
        if (release_reg) begin
            pending_n[wb.wid][wb.rd] = 1'b0;
        end
        if (reserve_reg) begin
            pending_n[issue.wid][issue.rd] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending     <= '0;
            deq_pending <= '0;
        end else begin
            pending     <= pending_n;
            deq_pending <= pending_n[deq_wid_next];  // follows the buffer's registered selection
        end
    end

    // covers both read-after-write and write-after-write on the same warp
    assign hazard_regs = deq_pending & issue.used_regs;
    assign hazard      = |hazard_regs;

    assign issue.ready = !(hazard || exe_delay);

endmodule

`default_nettype wire

//--- source/instr_buffer.sv
`timescale 1ns/10ps
`default_nettype none

`include "issue_cfg.svh"

module instr_buffer import issue_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    input  logic        in_valid,
    output logic        in_ready,
    input  wid_t        in_wid,
    input  tmask_t      in_tmask,
    input  exu_op_e     in_op,
    input  reg_idx_t    in_rd,
    input  reg_idx_t    in_rs1,
    input  reg_idx_t    in_rs2,
    input  logic [31:0] in_pc,

    decode_if.source    deq,
    output wid_t        deq_wid_next
);
    localparam int NW    = `NUM_WARPS;
    localparam int DEPTH = `IBUF_DEPTH;
    localparam int PW    = $clog2(DEPTH);
    localparam int CW    = $clog2(DEPTH + 1);

    tmask_t      q_tmask [NW][DEPTH];
    exu_op_e     q_op    [NW][DEPTH];
    reg_idx_t    q_rd    [NW][DEPTH];
    logic [31:0] q_pc    [NW][DEPTH];
    logic        q_wb    [NW][DEPTH];
    reg_mask_t   q_used  [NW][DEPTH];

    logic [NW-1:0][PW-1:0] wr_ptr, rd_ptr;
    logic [NW-1:0][CW-1:0] count, count_n;
    wid_t                  deq_wid;
    logic [PW-1:0]         head;
    logic                  push, pop, in_wb;
    reg_mask_t             in_used;

    function automatic logic [PW-1:0] ptr_inc(logic [PW-1:0] ptr);
        return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready = (count[in_wid] != CW'(DEPTH));  // only the addressed warp can be full
    assign push     = in_valid && in_ready;
    assign pop      = deq.valid && deq.ready;

    // decode register use once here so later stages never look at indices
    assign in_wb = (in_op == op_alu) || (in_op == op_mul);

    always_comb begin
        in_used = '0;
        in_used[in_rs1] = 1'b1;
        in_used[in_rs2] = 1'b1;
        if (in_wb) begin
            in_used[in_rd] = 1'b1;
        end
    end

    always_comb begin
        for (int w = 0; w < NW; w++) begin
            count_n[w] = count[w];
            if (push && in_wid == wid_t'(w)) count_n[w] = count_n[w] + 1'b1;
            if (pop && deq_wid == wid_t'(w)) count_n[w] = count_n[w] - 1'b1;
        end
    end

    // scan the other warps in round-robin order and consider the current warp last
    always_comb begin
        wid_t cand;
        deq_wid_next = deq_wid;
        for (int i = NW; i >= 1; i--) begin
            cand = wid_t'(deq_wid + wid_t'(i));
            if (count_n[cand] != '0) deq_wid_next = cand;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            deq_wid <= '0;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
        end else begin
            deq_wid <= deq_wid_next;
            count   <= count_n;
            if (push) wr_ptr[in_wid] <= ptr_inc(wr_ptr[in_wid]);
            if (pop) rd_ptr[deq_wid] <= ptr_inc(rd_ptr[deq_wid]);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            q_tmask[in_wid][wr_ptr[in_wid]] <= in_tmask;
            q_op[in_wid][wr_ptr[in_wid]]    <= in_op;
            q_rd[in_wid][wr_ptr[in_wid]]    <= in_rd;
            q_pc[in_wid][wr_ptr[in_wid]]    <= in_pc;
            q_wb[in_wid][wr_ptr[in_wid]]    <= in_wb;
            q_used[in_wid][wr_ptr[in_wid]]  <= in_used;
        end
    end

    assign head = rd_ptr[deq_wid];

    assign deq.valid     = (count[deq_wid] != '0);
    assign deq.wid       = deq_wid;
    assign deq.tmask     = q_tmask[deq_wid][head];
    assign deq.op        = q_op[deq_wid][head];
    assign deq.rd        = q_rd[deq_wid][head];
    assign deq.pc        = q_pc[deq_wid][head];
    assign deq.wb        = q_wb[deq_wid][head];
    assign deq.used_regs = q_used[deq_wid][head];

endmodule

`default_nettype wire

//--- source/writeback_if.sv
`timescale 1ns/10ps
`default_nettype none

interface writeback_if import issue_pkg::*; ();

    logic        valid;
    logic        ready;
    wid_t        wid;
    reg_idx_t    rd;
    tmask_t      tmask;
    logic [31:0] pc;

    modport source (
        output valid, wid, rd, tmask, pc,
        input  ready
    );

    // the scoreboard only watches completions
    modport sink (
        input valid, ready, wid, rd, tmask, pc
    );

endinterface

`default_nettype wire

//--- source/decode_if.sv
`timescale 1ns/10ps
`default_nettype none

interface decode_if import issue_pkg::*; ();

    logic        valid;
    logic        ready;
    wid_t        wid;
    tmask_t      tmask;
    exu_op_e     op;
    reg_idx_t    rd;
    logic [31:0] pc;
    logic        wb;         // instruction writes rd
    reg_mask_t   used_regs;  // every register the instruction names

    modport source (
        output valid, wid, tmask, op, rd, pc, wb, used_regs,
        input  ready
    );

    modport sink (
        input  valid, wid, tmask, op, rd, pc, wb, used_regs,
        output ready
    );

    modport monitor (
        input valid, ready, wid, tmask, op, rd, pc, wb, used_regs
    );

endinterface

`default_nettype wire

//--- source/issue_pkg.sv
`default_nettype none

`include "issue_cfg.svh"

package issue_pkg;

    // warp and register indices
    typedef logic [$clog2(`NUM_WARPS)-1:0] wid_t;
    typedef logic [$clog2(`NUM_REGS)-1:0]  reg_idx_t;

    // one bit per thread of a warp
    typedef logic [`NUM_THREADS-1:0] tmask_t;

    // one bit per architectural register
    typedef logic [`NUM_REGS-1:0] reg_mask_t;

    // branch and nop never write a register
    typedef enum logic [1:0] {
        op_nop    = 2'd0,
        op_alu    = 2'd1,
        op_mul    = 2'd2,
        op_branch = 2'd3
    } exu_op_e;

endpackage

`default_nettype wire

//--- source/issue_cfg.svh
`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

// core geometry
`define NUM_WARPS   4
`define NUM_REGS    32
`define NUM_THREADS 4

// entries in each per-warp instruction queue
`define IBUF_DEPTH  4

// cycles from issue to writeback valid for each unit
`define ALU_LATENCY 1
`define MUL_LATENCY 3

// the longest unit sets the depth of the execution pipeline
`define MAX_LATENCY `MUL_LATENCY

`endif
